// File: flist.f
+incdir+verilog
verilog/rs_pkg.sv
verilog/dispatch_decode.sv
verilog/reservation_station.sv
verilog/issue_execute.sv
verilog/result_regfile.sv
verilog/ooo_issue_top.sv
tb/tb_ooo_issue.sv

// File: Bender.yml
package:
  name: ooo_issue

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rs_pkg.sv
      - verilog/dispatch_decode.sv
      - verilog/reservation_station.sv
      - verilog/issue_execute.sv
      - verilog/result_regfile.sv
      - verilog/ooo_issue_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/tb_ooo_issue.sv

// File: tb/tb_ooo_issue.sv
`timescale 1ns/100ps
`include "rs_cfg.svh"

module tb_ooo_issue;
    import rs_pkg::*;

    localparam int INSTR_TOTAL = 8 + 6 + 14 + 4 + 8;      // Instructions over tests 2 to 6
    localparam int CYCLE_LIMIT = 4 * INSTR_TOTAL + 200;
    localparam int NEVER       = 1 << 30;                 // Tag not broadcast yet

    logic                        clock;
    logic                        reset;
    logic [`NUM_SCALAR_BITS-1:0] in_count;
    op_e [`N-1:0]                in_op;
    phys_reg_idx_t [`N-1:0]      in_dest;
    phys_reg_idx_t [`N-1:0]      in_src1;
    phys_reg_idx_t [`N-1:0]      in_src2;
    logic                        load_valid;
    phys_reg_idx_t               load_tag;
    logic [`DATA_W-1:0]          load_value;
    logic [`NUM_SCALAR_BITS-1:0] accepted_count;
    logic [`NUM_SCALAR_BITS-1:0] rs_spots;
    logic                        cdb_valid;
    phys_reg_idx_t               cdb_tag;
    logic [`DATA_W-1:0]          cdb_value;
    logic                        br_valid;
    logic                        br_mispred;

    logic [`DATA_W-1:0]   model_reg [`PREG_NUM];   // Register values in program order
    logic [`DATA_W-1:0]   exp_val   [`PREG_NUM];   // Value each pending tag must broadcast
    logic [`DATA_W-1:0]   prev_val  [`PREG_NUM];   // Put back when a producer is squashed
    logic [`PREG_NUM-1:0] pending;                 // Producer accepted, not yet broadcast
    logic [`PREG_NUM-1:0] spec;                    // Accepted under the open branch
    logic [1:0]           dep_on    [`PREG_NUM];   // Source had a producer in flight
    phys_reg_idx_t        dep_tag   [`PREG_NUM][2];
    int                   bcast_cyc [`PREG_NUM];
    int                   pend_cnt       = 0;
    int                   spec_bcast_cnt = 0;      // Young results seen before the resolve
    logic                 br_out         = 1'b0;   // BEQ accepted, not resolved
    logic                 exp_mispred    = 1'b0;
    logic                 idle_chk       = 1'b0;
    logic [`DATA_W-1:0]   exp_cdb;
    logic                 gap_ok;
    int                   cyc       = 0;
    int                   errors    = 0;
    int                   test_base = 0;

    op_e           prog_op   [$];                  // Program still to dispatch
    phys_reg_idx_t prog_dest [$];
    phys_reg_idx_t prog_src1 [$];
    phys_reg_idx_t prog_src2 [$];

    ooo_issue_top dut0 (
        .clock, .reset, .in_count, .in_op, .in_dest, .in_src1, .in_src2,
        .load_valid, .load_tag, .load_value, .accepted_count, .rs_spots,
        .cdb_valid, .cdb_tag, .cdb_value, .br_valid, .br_mispred
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) cyc <= cyc + 1;

    assign exp_cdb = exp_val[cdb_tag];
    // Consumer needs wakeup plus one select cycle after each producer result
    assign gap_ok = (!dep_on[cdb_tag][0] || cyc >= bcast_cyc[dep_tag[cdb_tag][0]] + 2)
                 && (!dep_on[cdb_tag][1] || cyc >= bcast_cyc[dep_tag[cdb_tag][1]] + 2);

    task automatic report_mismatch(input string sig, input int got, input int exp);
        errors++;
        $display("FAIL at %0t ns: %s is %0h, expected %0h", $time, sig, got, exp);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("At %0t ns: %s", $time, what);
    endtask

    a_idle_spots: assert property (@(negedge clock) disable iff (reset)
        idle_chk |-> rs_spots == `RS_SZ)
        else report_mismatch("rs_spots", $sampled(rs_spots), `RS_SZ);
    a_idle_quiet: assert property (@(negedge clock) disable iff (reset)
        idle_chk |-> !cdb_valid && !br_valid && accepted_count == 0)
        else report_problem("CDB, branch or accept output active right after reset");
    a_acc_in: assert property (@(posedge clock) disable iff (reset)
        accepted_count <= in_count)
        else report_problem("more lanes accepted than offered");
    a_acc_room: assert property (@(posedge clock) disable iff (reset)
        accepted_count <= rs_spots)
        else report_problem("more lanes accepted than free station entries");
    a_cdb_known: assert property (@(negedge clock) disable iff (reset)
        cdb_valid |-> pending[cdb_tag])
        else report_problem("broadcast on a tag with no live producer");
    a_cdb_value: assert property (@(negedge clock) disable iff (reset)
        cdb_valid && pending[cdb_tag] |-> cdb_value == exp_cdb)
        else report_mismatch("cdb_value", $sampled(cdb_value), $sampled(exp_cdb));
    a_cdb_order: assert property (@(negedge clock) disable iff (reset)
        cdb_valid && pending[cdb_tag] |-> gap_ok)
        else report_problem("result broadcast too soon after its producer");
    a_br_known: assert property (@(negedge clock) disable iff (reset)
        br_valid |-> br_out)
        else report_problem("branch resolved with no branch in flight");
    a_br_outcome: assert property (@(negedge clock) disable iff (reset)
        br_valid && br_out |-> br_mispred == exp_mispred)
        else report_mismatch("br_mispred", $sampled(br_mispred), $sampled(exp_mispred));
    a_squash_clean: assert property (@(negedge clock) disable iff (reset)
        br_valid && br_mispred |-> spec_bcast_cnt == 0)
        else report_problem("instruction younger than a mispredict broadcast");

    // Retire broadcasts and resolve branches in the model
    always @(negedge clock) begin
        if (!reset) begin
            if (cdb_valid && pending[cdb_tag]) begin
                pending[cdb_tag]   = 1'b0;
                pend_cnt--;
                bcast_cyc[cdb_tag] = cyc;
                if (spec[cdb_tag]) spec_bcast_cnt++;
            end
            if (br_valid) begin
                for (int t = 0; t < `PREG_NUM; t++) begin
                    if (br_mispred && spec[t] && pending[t]) begin
                        pending[t]   = 1'b0;             // Squashed, never broadcasts
                        pend_cnt--;
                        model_reg[t] = prev_val[t];
                    end
                end
                spec           = '0;
                br_out         = 1'b0;
                spec_bcast_cnt = 0;
            end
        end
    end

    function automatic logic [`DATA_W-1:0] alu_result(input op_e op,
                                                       input logic [`DATA_W-1:0] a,
                                                       input logic [`DATA_W-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            default: return '0;
        endcase
    endfunction

    task automatic add_instr(input op_e op, input int d, input int s1, input int s2);
        prog_op.push_back(op);
        prog_dest.push_back(phys_reg_idx_t'(d));
        prog_src1.push_back(phys_reg_idx_t'(s1));
        prog_src2.push_back(phys_reg_idx_t'(s2));
    endtask

    // Each link sources the previous dest, tag 1 is never written
    task automatic build_chain(input int len);
        for (int i = 0; i < len; i++) begin
            add_instr(op_e'($urandom % 4), 2 + i, (i == 0) ? 0 : 1 + i, 1);
        end
    endtask

    task automatic accept_instr(input int idx);
        op_e           op;
        phys_reg_idx_t d;
        phys_reg_idx_t s1;
        phys_reg_idx_t s2;
        op = prog_op[idx];
        d  = prog_dest[idx];
        s1 = prog_src1[idx];
        s2 = prog_src2[idx];
        if (op == OP_BEQ) begin
            exp_mispred = (model_reg[s1] == model_reg[s2]);  // Taken means mispredicted
            br_out      = 1'b1;
        end else begin
            dep_on[d]     = {pending[s2], pending[s1]};
            dep_tag[d][0] = s1;
            dep_tag[d][1] = s2;
            prev_val[d]   = model_reg[d];
            model_reg[d]  = alu_result(op, model_reg[s1], model_reg[s2]);
            exp_val[d]    = model_reg[d];
            spec[d]       = br_out;
            pending[d]    = 1'b1;
            bcast_cyc[d]  = NEVER;
            pend_cnt++;
        end
    endtask

    // Offer up to two lanes a cycle, re-offer whatever decode turns away
    task automatic dispatch_all();
        int pos;
        int offer;
        pos = 0;
        while (pos < prog_op.size()) begin
            @(negedge clock);
            offer = prog_op.size() - pos;
            if (offer > `N) offer = `N;
            in_count = offer[`NUM_SCALAR_BITS-1:0];
            for (int l = 0; l < offer; l++) begin
                in_op[l]   = prog_op[pos + l];
                in_dest[l] = prog_dest[pos + l];
                in_src1[l] = prog_src1[pos + l];
                in_src2[l] = prog_src2[pos + l];
            end
            #1;                                  // Decode settles on the new lanes
            for (int l = 0; l < accepted_count; l++) accept_instr(pos + l);
            pos = pos + accepted_count;
        end
        @(negedge clock);
        in_count = '0;
        prog_op.delete();
        prog_dest.delete();
        prog_src1.delete();
        prog_src2.delete();
    endtask

    task automatic preload(input int tag, input logic [`DATA_W-1:0] value);
        @(negedge clock);
        load_valid     = 1'b1;
        load_tag       = phys_reg_idx_t'(tag);
        load_value     = value;
        model_reg[tag] = value;
        @(negedge clock);
        load_valid     = 1'b0;
    endtask

    task automatic drain();
        while (pend_cnt != 0 || br_out) @(negedge clock);
        repeat (2) @(negedge clock);
    endtask

    task automatic close_test(input int num, input string name);
        drain();
        $display("Test %0d %s: %0d errors", num, name, errors - test_base);
        test_base = errors;
    endtask

    initial begin
        wait (cyc >= CYCLE_LIMIT);
        $display("Run hit the %0d cycle limit before the tests finished", CYCLE_LIMIT);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        void'($urandom(94));
        reset      = 1'b1;
        in_count   = '0;
        in_dest    = '0;
        in_src1    = '0;
        in_src2    = '0;
        load_valid = 1'b0;
        load_tag   = '0;
        load_value = '0;
        pending    = '0;
        spec       = '0;
        for (int l = 0; l < `N; l++) in_op[l] = OP_ADD;
        for (int t = 0; t < `PREG_NUM; t++) begin
            model_reg[t] = '0;                   // Register file clears on reset
            exp_val[t]   = '0;
            prev_val[t]  = '0;
            dep_on[t]    = '0;
            bcast_cyc[t] = NEVER;
        end
        repeat (3) @(negedge clock);
        reset = 1'b0;

        idle_chk = 1'b1;
        repeat (3) @(negedge clock);
        idle_chk = 1'b0;
        close_test(1, "reset state");

        for (int t = 0; t < `PREG_NUM; t++) preload(t, $urandom);
        for (int i = 0; i < 8; i++) begin
            add_instr(op_e'($urandom % 4), 8 + i, $urandom % 8, $urandom % 8);
        end
        dispatch_all();
        close_test(2, "independent ALU ops");

        build_chain(6);
        dispatch_all();
        close_test(3, "dependency chain");

        build_chain(14);                         // Outruns the 8 entries
        dispatch_all();
        close_test(4, "back-pressure");

        preload(0, $urandom);
        preload(1, model_reg[0] ^ 16'h00ff);     // Operands differ, not taken
        add_instr(OP_ADD, 4, 0, 1);
        add_instr(OP_BEQ, 0, 0, 1);
        add_instr(OP_SUB, 5, 4, 0);
        add_instr(OP_XOR, 6, 5, 1);
        dispatch_all();
        close_test(5, "correct branch");

        add_instr(OP_ADD, 2, 0, 1);
        add_instr(OP_SUB, 3, 1, 0);
        add_instr(OP_BEQ, 0, 0, 0);              // Same tag twice, always taken
        add_instr(OP_AND, 4, 3, 0);              // Young ops wait on tag 3
        add_instr(OP_XOR, 5, 3, 1);
        add_instr(OP_ADD, 6, 4, 5);
        dispatch_all();
        drain();
        add_instr(OP_ADD, 4, 5, 6);              // Squashed tags are free again
        add_instr(OP_SUB, 7, 4, 3);
        dispatch_all();
        close_test(6, "mispredict");

        $display("Summary: 6 tests run, %0d errors", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: verilog/ooo_issue_top.sv
`timescale 1ns/100ps
`include "rs_cfg.svh"

module ooo_issue_top (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [`NUM_SCALAR_BITS-1:0]       in_count,
    input  rs_pkg::op_e [`N-1:0]              in_op,
    input  rs_pkg::phys_reg_idx_t [`N-1:0]    in_dest,
    input  rs_pkg::phys_reg_idx_t [`N-1:0]    in_src1,
    input  rs_pkg::phys_reg_idx_t [`N-1:0]    in_src2,
    input  logic                              load_valid,
    input  rs_pkg::phys_reg_idx_t             load_tag,
    input  logic [`DATA_W-1:0]                load_value,
    output logic [`NUM_SCALAR_BITS-1:0]       accepted_count,
    output logic [`NUM_SCALAR_BITS-1:0]       rs_spots,
    output logic                              cdb_valid,
    output rs_pkg::phys_reg_idx_t             cdb_tag,
    output logic [`DATA_W-1:0]                cdb_value,
    output logic                              br_valid,
    output logic                              br_mispred
);
    import rs_pkg::*;

    logic [`NUM_SCALAR_BITS-1:0] num_dispatched;
    rs_packet_t [`N-1:0]         rs_entries;
    rs_packet_t [`RS_SZ-1:0]     rs_data;
    logic [`RS_SZ-1:0]           rs_valid_next;
    logic [`RS_SZ-1:0]           rs_data_issuing;
    phys_reg_idx_t               rd_tag1;
    phys_reg_idx_t               rd_tag2;
    logic [`DATA_W-1:0]          rd_value1;
    logic [`DATA_W-1:0]          rd_value2;
    b_mask_t                     b_mm_resolve;
    logic                        b_mm_mispred;

    dispatch_decode decode0 (
        .clock, .reset, .in_count, .in_op, .in_dest, .in_src1, .in_src2,
        .rs_spots, .cdb_valid, .cdb_tag, .b_mm_resolve, .b_mm_mispred,
        .accepted_count, .num_dispatched, .rs_entries
    );

    reservation_station rs0 (
        .clock, .reset, .num_dispatched, .rs_entries, .cdb_valid, .cdb_tag,
        .rs_data_issuing, .b_mm_resolve, .b_mm_mispred,
        .rs_spots, .rs_data, .rs_valid_next
    );

    issue_execute exec0 (
        .clock, .reset, .rs_data, .rs_valid_next, .rd_value1, .rd_value2,
        .rs_data_issuing, .rd_tag1, .rd_tag2, .cdb_valid, .cdb_tag, .cdb_value,
        .b_mm_resolve, .b_mm_mispred
    );

    result_regfile prf0 (
        .clock, .reset, .cdb_valid, .cdb_tag, .cdb_value,
        .load_valid, .load_tag, .load_value, .rd_tag1, .rd_tag2,
        .rd_value1, .rd_value2
    );

    assign br_valid   = |b_mm_resolve;  // One-hot resolve means a branch finished
    assign br_mispred = b_mm_mispred;

endmodule

// File: verilog/result_regfile.sv
`timescale 1ns/100ps
`include "rs_cfg.svh"

module result_regfile (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  cdb_valid,
    input  rs_pkg::phys_reg_idx_t cdb_tag,
    input  logic [`DATA_W-1:0]    cdb_value,
    input  logic                  load_valid,   // External preload
    input  rs_pkg::phys_reg_idx_t load_tag,
    input  logic [`DATA_W-1:0]    load_value,
    input  rs_pkg::phys_reg_idx_t rd_tag1,
    input  rs_pkg::phys_reg_idx_t rd_tag2,
    output logic [`DATA_W-1:0]    rd_value1,
    output logic [`DATA_W-1:0]    rd_value2
);
    import rs_pkg::*;

    logic [`DATA_W-1:0] regs [`PREG_NUM];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int t = 0; t < `PREG_NUM; t++) regs[t] <= '0;
        end else begin
            if (load_valid) regs[load_tag] <= load_value;
            if (cdb_valid)  regs[cdb_tag] <= cdb_value;  // CDB beats preload on the same tag
        end
    end

    // Bypass the broadcast that lands at the end of this cycle
    assign rd_value1 = (cdb_valid && cdb_tag == rd_tag1) ? cdb_value : regs[rd_tag1];
    assign rd_value2 = (cdb_valid && cdb_tag == rd_tag2) ? cdb_value : regs[rd_tag2];

endmodule

// File: verilog/issue_execute.sv
`timescale 1ns/100ps
`include "rs_cfg.svh"

module issue_execute (
    input  logic                              clock,
    input  logic                              reset,
    input  rs_pkg::rs_packet_t [`RS_SZ-1:0]   rs_data,
    input  logic [`RS_SZ-1:0]                 rs_valid_next,
    input  logic [`DATA_W-1:0]                rd_value1,     // Operands for the picked entry
    input  logic [`DATA_W-1:0]                rd_value2,
    output logic [`RS_SZ-1:0]                 rs_data_issuing,
    output rs_pkg::phys_reg_idx_t             rd_tag1,
    output rs_pkg::phys_reg_idx_t             rd_tag2,
    output logic                              cdb_valid,
    output rs_pkg::phys_reg_idx_t             cdb_tag,
    output logic [`DATA_W-1:0]                cdb_value,
    output rs_pkg::b_mask_t                   b_mm_resolve,
    output logic                              b_mm_mispred
);
    import rs_pkg::*;

    logic [`RS_SZ-1:0]  sel_oh;
    rs_packet_t         sel_pkt;
    logic               found;
    logic               ex_valid;   // Op held in the execute register
    op_e                ex_op;
    logic [`DATA_W-1:0] ex_a;
    logic [`DATA_W-1:0] ex_b;
    phys_reg_idx_t      ex_dest;
    logic [`DATA_W-1:0] alu_out;
    logic               is_br;

    // Lowest-index entry with both sources ready
    always_comb begin
        sel_oh  = '0;
        sel_pkt = '0;
        found   = 1'b0;
        for (int i = 0; i < `RS_SZ; i++) begin
            if (!found && rs_valid_next[i] && rs_data[i].src1_ready && rs_data[i].src2_ready) begin
                found     = 1'b1;
                sel_oh[i] = 1'b1;
                sel_pkt   = rs_data[i];
            end
        end
    end

    assign rs_data_issuing = sel_oh;
    assign rd_tag1         = sel_pkt.src1;
    assign rd_tag2         = sel_pkt.src2;

    always_ff @(posedge clock) begin
        if (reset) ex_valid <= 1'b0;
        else       ex_valid <= found && !(b_mm_mispred && |(sel_pkt.b_mask & b_mm_resolve));
    end

    always_ff @(posedge clock) begin
        ex_op   <= sel_pkt.op;
        ex_a    <= rd_value1;
        ex_b    <= rd_value2;
        ex_dest <= sel_pkt.dest;
    end

    always_comb begin
        case (ex_op)
            OP_ADD:  alu_out = ex_a + ex_b;
            OP_SUB:  alu_out = ex_a - ex_b;
            OP_AND:  alu_out = ex_a & ex_b;
            OP_XOR:  alu_out = ex_a ^ ex_b;
            default: alu_out = ex_a - ex_b;  // BEQ compare, result unused
        endcase
    end

    assign is_br        = ex_valid && (ex_op == OP_BEQ);
    assign cdb_valid    = ex_valid && (ex_op != OP_BEQ);
    assign cdb_tag      = ex_dest;
    assign cdb_value    = alu_out;
    assign b_mm_resolve = is_br ? ex_dest[`B_MASK_W-1:0] : '0;  // Own bit from the dest field
    assign b_mm_mispred = is_br && (ex_a == ex_b);              // Predicted not taken

    a_cdb_or_branch: assert property (@(posedge clock) disable iff (reset)
        !(cdb_valid && |b_mm_resolve));

endmodule

// File: verilog/reservation_station.sv
`timescale 1ns/100ps
`include "rs_cfg.svh"

module reservation_station (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [`NUM_SCALAR_BITS-1:0]       num_dispatched,  // Valid packets in rs_entries
    input  rs_pkg::rs_packet_t [`N-1:0]       rs_entries,
    input  logic                              cdb_valid,
    input  rs_pkg::phys_reg_idx_t             cdb_tag,
    input  logic [`RS_SZ-1:0]                 rs_data_issuing, // One-hot pick from execute
    input  rs_pkg::b_mask_t                   b_mm_resolve,
    input  logic                              b_mm_mispred,
    output logic [`NUM_SCALAR_BITS-1:0]       rs_spots,
    output rs_pkg::rs_packet_t [`RS_SZ-1:0]   rs_data,
    output logic [`RS_SZ-1:0]                 rs_valid_next    // Valid after squash
);
    import rs_pkg::*;

    logic [`RS_SZ-1:0] rs_valid;
    logic [`RS_SZ-1:0] slot_oh [`N];  // Entry picked for each lane
    logic [`RS_SZ-1:0] alloc_vec;     // Entries filled at this edge

    // Lane l takes the l-th lowest free entry
    always_comb begin
        logic [`RS_SZ-1:0] free_vec;

        free_vec  = ~rs_valid;
        alloc_vec = '0;
        for (int l = 0; l < `N; l++) begin
            slot_oh[l] = '0;
            for (int i = `RS_SZ - 1; i >= 0; i--) begin
                if (free_vec[i]) slot_oh[l] = `RS_SZ'(1) << i;  // Lowest index wins
            end
            free_vec = free_vec & ~slot_oh[l];
            if (l < num_dispatched) alloc_vec = alloc_vec | slot_oh[l];
        end
    end

    // Counted off registered valids, so entries leaving now free up next cycle
    always_comb begin
        rs_spots = '0;
        for (int i = 0; i < `RS_SZ; i++) begin
            if (!rs_valid[i]) rs_spots = rs_spots + 1'b1;
        end
    end

    // Squash anything under the mispredicted bit
    always_comb begin
        for (int i = 0; i < `RS_SZ; i++) begin
            rs_valid_next[i] = rs_valid[i]
                && !(b_mm_mispred && |(rs_data[i].b_mask & b_mm_resolve));
        end
    end

    always_ff @(posedge clock) begin
        if (reset) rs_valid <= '0;
        else       rs_valid <= (rs_valid_next & ~rs_data_issuing) | alloc_vec;
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `RS_SZ; i++) begin
            rs_data[i].b_mask <= rs_data[i].b_mask & ~b_mm_resolve;  // Resolved bit drops out
            // Wakeup
            if (cdb_valid && rs_data[i].src1 == cdb_tag) rs_data[i].src1_ready <= 1'b1;
            if (cdb_valid && rs_data[i].src2 == cdb_tag) rs_data[i].src2_ready <= 1'b1;
            for (int l = 0; l < `N; l++) begin
                if (l < num_dispatched && slot_oh[l][i]) rs_data[i] <= rs_entries[l];
            end
        end
    end

    a_issue_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(rs_data_issuing));

    // Execute may only pick an entry that survives squash
    a_issue_valid: assert property (@(posedge clock) disable iff (reset)
        (rs_data_issuing & ~rs_valid_next) == '0);

endmodule

// File: verilog/dispatch_decode.sv
`timescale 1ns/100ps
`include "rs_cfg.svh"

module dispatch_decode (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [`NUM_SCALAR_BITS-1:0]       in_count,       // Lanes offered, lowest first
    input  rs_pkg::op_e [`N-1:0]              in_op,
    input  rs_pkg::phys_reg_idx_t [`N-1:0]    in_dest,
    input  rs_pkg::phys_reg_idx_t [`N-1:0]    in_src1,
    input  rs_pkg::phys_reg_idx_t [`N-1:0]    in_src2,
    input  logic [`NUM_SCALAR_BITS-1:0]       rs_spots,       // Free station entries
    input  logic                              cdb_valid,
    input  rs_pkg::phys_reg_idx_t             cdb_tag,
    input  rs_pkg::b_mask_t                   b_mm_resolve,
    input  logic                              b_mm_mispred,
    output logic [`NUM_SCALAR_BITS-1:0]       accepted_count,
    output logic [`NUM_SCALAR_BITS-1:0]       num_dispatched,
    output rs_pkg::rs_packet_t [`N-1:0]       rs_entries
);
    import rs_pkg::*;

    logic [`PREG_NUM-1:0]        busy;                  // Tag waits on a producer
    logic [`PREG_NUM-1:0]        busy_next;
    b_mask_t                     cur_mask;              // Branch bits in use
    b_mask_t                     mask_next;
    b_mask_t                     tag_mask [`PREG_NUM];  // Mask of each tag's latest producer
    b_mask_t                     br_dep   [`B_MASK_W];  // Full mask of the branch owning a bit
    b_mask_t                     own_bit  [`N];         // Bit granted to a BEQ lane
    logic [`NUM_SCALAR_BITS-1:0] acc;

    always_comb begin
        b_mask_t                     run_mask;
        b_mask_t                     avail;
        logic [`NUM_SCALAR_BITS-1:0] limit;
        logic                        stop;
        logic                        take;

        busy_next = busy;
        if (cdb_valid) busy_next[cdb_tag] = 1'b0;  // Same-cycle broadcast counts as ready
        if (b_mm_mispred) begin
            for (int t = 0; t < `PREG_NUM; t++) begin
                // Squashed producers will never broadcast
                if (|(tag_mask[t] & b_mm_resolve)) busy_next[t] = 1'b0;
            end
        end

        // Free bits of the mispredicted branch and of every branch younger than it
        mask_next = cur_mask & ~b_mm_resolve;
        if (b_mm_mispred) begin
            for (int b = 0; b < `B_MASK_W; b++) begin
                if (|(br_dep[b] & b_mm_resolve)) mask_next[b] = 1'b0;
            end
        end

        run_mask = cur_mask & ~b_mm_resolve;  // Bit resolving now is not carried forward
        avail    = ~cur_mask;                 // A freed bit is reusable only next cycle
        limit    = (in_count < rs_spots) ? in_count : rs_spots;
        stop     = b_mm_mispred;              // Nothing enters during a mispredict
        acc      = '0;
        for (int l = 0; l < `N; l++) begin
            own_bit[l] = '0;
            take       = !stop && (l < limit);
            if (take && in_op[l] == OP_BEQ) begin
                if (avail == '0) take = 1'b0;                 // No branch bit left
                else own_bit[l] = avail & (~avail + 1'b1);   // Lowest free bit
            end
            avail     = avail & ~own_bit[l];
            run_mask  = run_mask | own_bit[l];  // Branch and all younger lanes carry it
            mask_next = mask_next | own_bit[l];

            rs_entries[l].op         = in_op[l];
            rs_entries[l].dest       = (in_op[l] == OP_BEQ) ? phys_reg_idx_t'(own_bit[l])
                                                            : in_dest[l];
            rs_entries[l].src1       = in_src1[l];
            rs_entries[l].src2       = in_src2[l];
            rs_entries[l].src1_ready = !busy_next[in_src1[l]];
            rs_entries[l].src2_ready = !busy_next[in_src2[l]];
            rs_entries[l].b_mask     = run_mask;

            if (take) begin
                acc = acc + 1'b1;
                // Older lane's dest is busy for the younger lanes too
                if (in_op[l] != OP_BEQ) busy_next[in_dest[l]] = 1'b1;
            end
            stop = stop || !take;  // Accepted lanes stay contiguous
        end
    end

    assign accepted_count = acc;
    assign num_dispatched = acc;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy     <= '0;
            cur_mask <= '0;
            for (int t = 0; t < `PREG_NUM; t++) tag_mask[t] <= '0;
            for (int b = 0; b < `B_MASK_W; b++) br_dep[b] <= '0;
        end else begin
            busy     <= busy_next;
            cur_mask <= mask_next;
            for (int t = 0; t < `PREG_NUM; t++) tag_mask[t] <= tag_mask[t] & ~b_mm_resolve;
            for (int b = 0; b < `B_MASK_W; b++) br_dep[b] <= br_dep[b] & ~b_mm_resolve;
            for (int l = 0; l < `N; l++) begin
                if (l < acc) begin
                    if (in_op[l] == OP_BEQ) begin
                        for (int b = 0; b < `B_MASK_W; b++) begin
                            if (own_bit[l][b]) br_dep[b] <= rs_entries[l].b_mask;
                        end
                    end else begin
                        tag_mask[in_dest[l]] <= rs_entries[l].b_mask;  // Later lane wins
                    end
                end
            end
        end
    end

    // Station must never be asked to take more than it has room for
    a_acc_le_spots: assert property (@(posedge clock) disable iff (reset)
        accepted_count <= rs_spots);

endmodule

// File: verilog/rs_pkg.sv
`include "rs_cfg.svh"

package rs_pkg;

    // ALU ops plus the one branch kind
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_XOR,
        OP_BEQ
    } op_e;

    typedef logic [`PREG_W-1:0]   phys_reg_idx_t;
    typedef logic [`B_MASK_W-1:0] b_mask_t;       // One bit per branch in flight

    // Branch bits are handed out one-hot by decode.
    // A BEQ has no dest register, so its dest field holds its own mask bit instead.
    typedef struct packed {
        op_e           op;
        phys_reg_idx_t dest;
        phys_reg_idx_t src1;
        phys_reg_idx_t src2;
        logic          src1_ready;
        logic          src2_ready;
        b_mask_t       b_mask;      // Unresolved branches this packet sits under
    } rs_packet_t;

endpackage

// File: verilog/rs_cfg.svh
`ifndef RS_CFG_SVH
`define RS_CFG_SVH

// Dispatch lanes per cycle
`define N               2

// Reservation station entries
`define RS_SZ           8

// Spot and dispatch counts, wide enough to hold RS_SZ
`define NUM_SCALAR_BITS 4

// Physical register tags
`define PREG_NUM        16
`define PREG_W          4

// Operand and result width
`define DATA_W          16

// Max unresolved branches, one mask bit each
`define B_MASK_W        2

`endif
